// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isa_pkg.sv
      - verilog/uarch_pkg.sv
      - verilog/dispatch_unit.sv
      - verilog/exec_lane.sv
      - verilog/reorder_buffer.sv
      - verilog/ooo_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/ooo_core_tb.sv

// ==== all.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/uarch_pkg.sv
verilog/dispatch_unit.sv
verilog/exec_lane.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
verification/ooo_core_tb.sv

// ==== verification/ooo_core_tb.sv ====
// out-of-order core testbench
// runs a table of operations through the core, checks every retire
// against a model in program order, with random retire back-pressure

`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module ooo_core_tb import isa_pkg::*; ();

	localparam int NUM_ROWS       = 16;
	localparam int TIMEOUT_CYCLES = 20 * NUM_ROWS + 100;
	localparam int POST_HALT      = 8;

	// DUT ports
	logic           clock;
	logic           reset;
	logic           in_valid;
	op_code_t       in_op;
	data_t          in_a;
	data_t          in_b;
	reg_idx_t       in_dest;
	logic           out_ready;
	logic           in_ready;
	logic           out_valid;
	data_t          out_result;
	reg_idx_t       out_dest;
	retire_status_t out_status;
	logic           halted;

	// stimulus table held as raw 3 bit codes so 6 and 7 fit
	string      row_name [NUM_ROWS];
	logic [2:0] row_op   [NUM_ROWS];
	data_t      row_a    [NUM_ROWS];
	data_t      row_b    [NUM_ROWS];
	reg_idx_t   row_dest [NUM_ROWS];

	// scoreboard of row indices in acceptance order
	int         expect_q [$];
	int         accepted_count;
	int         retired_count;
	int         cycle_count;
	logic [7:0] lfsr_state;

	ooo_core UUT (
		.clock      (clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.in_dest    (in_dest),
		.out_ready  (out_ready),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_dest   (out_dest),
		.out_status (out_status),
		.halted     (halted)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	endtask

	task automatic set_row(int idx, string name, logic [2:0] op, data_t a, data_t b,
			reg_idx_t dest);
		row_name[idx] = name;
		row_op[idx]   = op;
		row_a[idx]    = a;
		row_b[idx]    = b;
		row_dest[idx] = dest;
	endtask

	// mul rows followed by quick ALU rows to force out of order completion
	task automatic load_table();
		set_row(0,  "add_basic",         3'd0, 32'h0000_0005, 32'h0000_0007, 5'd1);
		set_row(1,  "sub_wrap",          3'd1, 32'h0000_0003, 32'h0000_000a, 5'd2);
		set_row(2,  "and_mask",          3'd2, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd3);
		set_row(3,  "xor_flip",          3'd3, 32'haaaa_5555, 32'hffff_0000, 5'd4);
		set_row(4,  "mul_small",         3'd4, 32'h0000_0006, 32'h0000_0007, 5'd5);
		set_row(5,  "add_after_mul",     3'd0, 32'h7fff_ffff, 32'h0000_0001, 5'd6);
		set_row(6,  "xor_after_mul",     3'd3, 32'h1234_5678, 32'h1234_5678, 5'd7);
		set_row(7,  "mul_wide",          3'd4, 32'hffff_ffff, 32'h0000_0002, 5'd8);
		set_row(8,  "mul_chain",         3'd4, 32'h0001_0000, 32'h0001_0003, 5'd9);
		set_row(9,  "sub_after_mul",     3'd1, 32'h0000_0000, 32'h0000_0001, 5'd10);
		set_row(10, "illegal_6",         3'd6, 32'hdead_beef, 32'h0000_0001, 5'd11);
		set_row(11, "add_after_illegal", 3'd0, 32'h0000_0064, 32'h0000_0017, 5'd12);
		set_row(12, "illegal_7",         3'd7, 32'h0000_0005, 32'h0000_0005, 5'd13);
		set_row(13, "mul_after_illegal", 3'd4, 32'h0000_1234, 32'h0000_5678, 5'd14);
		set_row(14, "and_last",          3'd2, 32'hffff_ffff, 32'h8000_0001, 5'd31);
		set_row(15, "halt_final",        3'd5, 32'h0000_0000, 32'h0000_0000, 5'd0);
	endtask

	// expected result from the op rules
	function automatic data_t model_result(logic [2:0] op, data_t a, data_t b);
		logic [2*`XLEN-1:0] full;
		full = a * b;
		case (op)
			3'd0:    return a + b;
			3'd1:    return a - b;
			3'd2:    return a & b;
			3'd3:    return a ^ b;
			// low half of the full product
			3'd4:    return full[`XLEN-1:0];
			default: return '0;
		endcase
	endfunction

	function automatic retire_status_t model_status(logic [2:0] op);
		if (op <= 3'd4) begin
			return OK;
		end else if (op == 3'd5) begin
			return HALTED;
		end else begin
			return ILLEGAL;
		end
	endfunction

	// fibonacci lfsr with taps for x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	////////////////////////////////////////////////////////////
	// clock and back-pressure and timeout
	////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// one lfsr step per ready bit
	always @(posedge clock) begin
		if (!reset) begin
			#2;
			lfsr_state = lfsr_step(lfsr_state);
			out_ready  = lfsr_state[0];
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	////////////////////////////////////////////////////////////
	// retire monitor
	////////////////////////////////////////////////////////////

	// sampled mid cycle since the transfer happens at the next edge
	always @(negedge clock) begin : retire_monitor
		int             idx;
		data_t          exp_result;
		retire_status_t exp_status;
		if (!reset && out_valid && out_ready) begin
			assert (expect_q.size() > 0) else begin
				$display("retire seen with no operation outstanding, dest %0d", out_dest);
				stop_run();
			end
			idx        = expect_q.pop_front();
			exp_result = model_result(row_op[idx], row_a[idx], row_b[idx]);
			exp_status = model_status(row_op[idx]);
			assert (out_result == exp_result) else begin
				$display("FAILED %s: result expected %h actual %h",
					row_name[idx], exp_result, out_result);
				stop_run();
			end
			assert (out_dest == row_dest[idx]) else begin
				$display("FAILED %s: dest expected %0d actual %0d",
					row_name[idx], row_dest[idx], out_dest);
				stop_run();
			end
			assert (out_status == exp_status) else begin
				$display("FAILED %s: status expected %s actual %s",
					row_name[idx], exp_status.name(), out_status.name());
				stop_run();
			end
			// halt is the last row, so halted stays low until it leaves
			assert (!halted) else begin
				$display("FAILED %s: halted expected 0 actual 1", row_name[idx]);
				stop_run();
			end
			retired_count = retired_count + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin : main_sequence
		logic accepted;
		in_valid       = 1'b0;
		in_op          = ADD;
		in_a           = '0;
		in_b           = '0;
		in_dest        = '0;
		out_ready      = 1'b0;
		reset          = 1'b1;
		accepted_count = 0;
		retired_count  = 0;
		cycle_count    = 0;
		lfsr_state     = 8'd5;
		load_table();

		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;

		// idle state right after reset
		@(negedge clock);
		assert (in_ready && !out_valid && !halted) else begin
			$display("core not idle after reset, in_ready %b out_valid %b halted %b",
				in_ready, out_valid, halted);
			stop_run();
		end
		@(posedge clock);
		#2;

		// feed each row and hold it until accepted
		for (int i = 0; i < NUM_ROWS; i++) begin
			in_valid = 1'b1;
			in_op    = op_code_t'(row_op[i]);
			in_a     = row_a[i];
			in_b     = row_b[i];
			in_dest  = row_dest[i];
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clock);
				if (in_ready) begin
					accepted = 1'b1;
					expect_q.push_back(i);
					accepted_count = accepted_count + 1;
				end
				@(posedge clock);
				#2;
			end
		end
		in_valid = 1'b0;

		// drain until the halt entry has retired
		while (!halted) begin
			@(negedge clock);
		end

		// core must stay stopped after the halt
		repeat (POST_HALT) begin
			@(posedge clock);
			#2;
			in_valid = 1'b1;
			in_op    = ADD;
			in_a     = 32'h0000_0001;
			in_b     = 32'h0000_0001;
			in_dest  = 5'd20;
			@(negedge clock);
			assert (halted && !in_ready && !out_valid) else begin
				$display("core not stopped after halt, halted %b in_ready %b out_valid %b",
					halted, in_ready, out_valid);
				stop_run();
			end
		end
		in_valid = 1'b0;

		// every accepted row must have come back out before halted rose
		assert (retired_count == accepted_count) begin
			$display("PASS: all tests");
		end else begin
			$display("count mismatch, accepted %0d retired %0d",
				accepted_count, retired_count);
			stop_run();
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/core_defines.svh ====
// core defines
// sizing macros shared by the packages and the RTL of the
// out-of-order execute and retire core

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////

// operand and result width
`define XLEN 32
// destination register index width
`define REG_IDX_BITS 5

////////////////////////////////////////////////////////////
// machine sizing
////////////////////////////////////////////////////////////

// reorder buffer entries, power of two
`define ROB_SIZE 8
// identical execution lanes
`define LANES 2
// multiply pipeline depth, at least 2
`define MUL_LATENCY 3

`endif

// ==== verilog/dispatch_unit.sv ====
// dispatch unit
// decodes incoming operations, reserves a reorder buffer entry
// and issues ALU and multiply work to a lane in the same cycle

`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module dispatch_unit import isa_pkg::*; import uarch_pkg::*; (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           in_valid,
	input  op_code_t                       in_op,
	input  data_t                          in_a,
	input  data_t                          in_b,
	input  reg_idx_t                       in_dest,
	input  logic                           alloc_ready,
	input  rob_tag_t                       alloc_tag,
	input  logic         [`LANES-1:0]      alu_ready,
	output logic                           in_ready,
	output logic                           alloc_valid,
	output reg_idx_t                       alloc_dest,
	output logic                           alloc_done,
	output retire_status_t                 alloc_status,
	output logic         [`LANES-1:0]      issue_valid,
	output op_code_t     [`LANES-1:0]      issue_op,
	output data_t        [`LANES-1:0]      issue_a,
	output data_t        [`LANES-1:0]      issue_b,
	output rob_tag_t     [`LANES-1:0]      issue_tag
);

	logic      is_alu;
	logic      is_mul;
	logic      is_halt;
	logic      is_illegal;
	logic      lane_ok;
	lane_idx_t lane_sel;
	logic      accept;
	logic      halt_seen;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	assign is_alu     = in_op inside {ADD, SUB, AND, XOR};
	assign is_mul     = in_op == MUL;
	assign is_halt    = in_op == HALT;
	// anything else, i.e. codes 6 and 7
	assign is_illegal = !(is_alu || is_mul || is_halt);

	// lane pick
	// multiplies always land in lane 0, no ready needed
	// ALU ops take the lowest lane with a free writeback slot
	always_comb begin
		lane_ok  = 1'b1;
		lane_sel = '0;
		if (is_alu) begin
			lane_ok = 1'b0;
			// walk downward so the lowest ready lane wins
			for (int l = `LANES - 1; l >= 0; l--) begin
				if (alu_ready[l]) begin
					lane_ok  = 1'b1;
					lane_sel = lane_idx_t'(l);
				end
			end
		end
	end

	// stall on full rob, busy lanes, or once a halt went in
	assign in_ready = !halt_seen && alloc_ready && (!in_valid || lane_ok);
	assign accept   = in_valid && in_ready;

	////////////////////////////////////////////////////////////
	// reorder buffer allocation
	////////////////////////////////////////////////////////////

	assign alloc_valid = accept;
	assign alloc_dest  = in_dest;
	// illegal and halt never visit a lane
	assign alloc_done  = is_illegal || is_halt;
	assign alloc_status = is_illegal ? ILLEGAL : (is_halt ? HALTED : OK);

	// issue, payload is broadcast and valid selects the lane
	always_comb begin
		for (int l = 0; l < `LANES; l++) begin
			issue_valid[l] = accept && (is_alu || is_mul) && (lane_sel == lane_idx_t'(l));
			issue_op[l]    = in_op;
			issue_a[l]     = in_a;
			issue_b[l]     = in_b;
			issue_tag[l]   = alloc_tag;
		end
	end

	// halt seen, sticky until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			halt_seen <= 1'b0;
		end else if (accept && is_halt) begin
			halt_seen <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/exec_lane.sv ====
// execution lane
// single cycle ALU path plus a pipelined multiply, both
// draining through one registered writeback port

`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module exec_lane import isa_pkg::*; import uarch_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     issue_valid,
	input  op_code_t issue_op,
	input  data_t    issue_a,
	input  data_t    issue_b,
	input  rob_tag_t issue_tag,
	output logic     alu_ready,
	output logic     wb_valid,
	output rob_tag_t wb_tag,
	output data_t    wb_result
);

	localparam int STAGES = `MUL_LATENCY;
	localparam int LAST   = STAGES - 1;

	// shift pipeline, stage LAST feeds the writeback port
	logic [STAGES-1:0] st_valid;
	rob_tag_t          st_tag    [STAGES];
	data_t             st_result [STAGES];

	logic  is_mul;
	logic  alu_take;
	logic  mul_take;
	data_t alu_result;
	data_t product;

	assign is_mul   = issue_op == MUL;
	assign mul_take = issue_valid && is_mul;
	assign alu_take = issue_valid && !is_mul;

	// an ALU op drops straight into the last stage
	// blocked while the stage behind it would shift in
	assign alu_ready = ~st_valid[STAGES-2];

	////////////////////////////////////////////////////////////
	// compute
	////////////////////////////////////////////////////////////

	always_comb begin
		case (issue_op)
			ADD:     alu_result = issue_a + issue_b;
			SUB:     alu_result = issue_a - issue_b;
			AND:     alu_result = issue_a & issue_b;
			XOR:     alu_result = issue_a ^ issue_b;
			default: alu_result = '0;
		endcase
	end

	// low half of the product only
	assign product = issue_a * issue_b;

	////////////////////////////////////////////////////////////
	// pipeline control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			st_valid <= '0;
		end else begin
			st_valid[0] <= mul_take;
			for (int s = 1; s < LAST; s++) begin
				st_valid[s] <= st_valid[s-1];
			end
			// the two sources never coincide, see alu_ready
			st_valid[LAST] <= st_valid[LAST-1] | alu_take;
		end
	end

	// pipeline payload
	always_ff @(posedge clock) begin
		if (mul_take) begin
			st_tag[0]    <= issue_tag;
			st_result[0] <= product;
		end
		for (int s = 1; s < LAST; s++) begin
			st_tag[s]    <= st_tag[s-1];
			st_result[s] <= st_result[s-1];
		end
		if (alu_take) begin
			st_tag[LAST]    <= issue_tag;
			st_result[LAST] <= alu_result;
		end else begin
			st_tag[LAST]    <= st_tag[LAST-1];
			st_result[LAST] <= st_result[LAST-1];
		end
	end

	// writeback straight from the last stage registers
	assign wb_valid  = st_valid[LAST];
	assign wb_tag    = st_tag[LAST];
	assign wb_result = st_result[LAST];

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
// isa package
// architectural types seen at the core boundary: data words,
// register indices, operation codes and retire status

`default_nettype none

`include "core_defines.svh"

package isa_pkg;

	// operand or result word
	typedef logic [`XLEN-1:0] data_t;

	// destination register index
	typedef logic [`REG_IDX_BITS-1:0] reg_idx_t;

	// codes 6 and 7 stay unnamed, decoded as illegal
	typedef enum logic [2:0] {
		ADD  = 3'd0,
		SUB  = 3'd1,
		AND  = 3'd2,
		XOR  = 3'd3,
		MUL  = 3'd4,
		HALT = 3'd5
	} op_code_t;

	// status carried out on the retire port
	typedef enum logic [1:0] {
		OK      = 2'd0,
		ILLEGAL = 2'd1,
		HALTED  = 2'd2
	} retire_status_t;

endpackage

`default_nettype wire

// ==== verilog/ooo_core.sv ====
// out-of-order core top
// dispatch unit, replicated execution lanes and reorder buffer

`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module ooo_core import isa_pkg::*; import uarch_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  logic           in_valid,
	input  op_code_t       in_op,
	input  data_t          in_a,
	input  data_t          in_b,
	input  reg_idx_t       in_dest,
	input  logic           out_ready,
	output logic           in_ready,
	output logic           out_valid,
	output data_t          out_result,
	output reg_idx_t       out_dest,
	output retire_status_t out_status,
	output logic           halted
);

	// dispatch to rob
	logic           alloc_ready;
	rob_tag_t       alloc_tag;
	logic           alloc_valid;
	reg_idx_t       alloc_dest;
	logic           alloc_done;
	retire_status_t alloc_status;

	// dispatch to lanes
	logic     [`LANES-1:0] issue_valid;
	op_code_t [`LANES-1:0] issue_op;
	data_t    [`LANES-1:0] issue_a;
	data_t    [`LANES-1:0] issue_b;
	rob_tag_t [`LANES-1:0] issue_tag;
	logic     [`LANES-1:0] alu_ready;

	// lanes to rob
	logic     [`LANES-1:0] wb_valid;
	rob_tag_t [`LANES-1:0] wb_tag;
	data_t    [`LANES-1:0] wb_result;

	dispatch_unit dispatch (
		.clock        (clock),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_a         (in_a),
		.in_b         (in_b),
		.in_dest      (in_dest),
		.alloc_ready  (alloc_ready),
		.alloc_tag    (alloc_tag),
		.alu_ready    (alu_ready),
		.in_ready     (in_ready),
		.alloc_valid  (alloc_valid),
		.alloc_dest   (alloc_dest),
		.alloc_done   (alloc_done),
		.alloc_status (alloc_status),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_a      (issue_a),
		.issue_b      (issue_b),
		.issue_tag    (issue_tag)
	);

	////////////////////////////////////////////////////////////
	// execution lanes
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `LANES; g++) begin : gen_lane
		exec_lane lane (
			.clock       (clock),
			.reset       (reset),
			.issue_valid (issue_valid[g]),
			.issue_op    (issue_op[g]),
			.issue_a     (issue_a[g]),
			.issue_b     (issue_b[g]),
			.issue_tag   (issue_tag[g]),
			.alu_ready   (alu_ready[g]),
			.wb_valid    (wb_valid[g]),
			.wb_tag      (wb_tag[g]),
			.wb_result   (wb_result[g])
		);
	end

	reorder_buffer rob (
		.clock        (clock),
		.reset        (reset),
		.alloc_valid  (alloc_valid),
		.alloc_dest   (alloc_dest),
		.alloc_done   (alloc_done),
		.alloc_status (alloc_status),
		.wb_valid     (wb_valid),
		.wb_tag       (wb_tag),
		.wb_result    (wb_result),
		.out_ready    (out_ready),
		.alloc_ready  (alloc_ready),
		.alloc_tag    (alloc_tag),
		.out_valid    (out_valid),
		.out_result   (out_result),
		.out_dest     (out_dest),
		.out_status   (out_status),
		.halted       (halted)
	);

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
// reorder buffer
// circular buffer of in-flight operations, completed out of
// order by lane writebacks and retired one per cycle in order

`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module reorder_buffer import isa_pkg::*; import uarch_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         alloc_valid,
	input  reg_idx_t                     alloc_dest,
	input  logic                         alloc_done,
	input  retire_status_t               alloc_status,
	input  logic         [`LANES-1:0]    wb_valid,
	input  rob_tag_t     [`LANES-1:0]    wb_tag,
	input  data_t        [`LANES-1:0]    wb_result,
	input  logic                         out_ready,
	output logic                         alloc_ready,
	output rob_tag_t                     alloc_tag,
	output logic                         out_valid,
	output data_t                        out_result,
	output reg_idx_t                     out_dest,
	output retire_status_t               out_status,
	output logic                         halted
);

	localparam int DEPTH = `ROB_SIZE;
	localparam int CNT_BITS = $clog2(DEPTH) + 1;

	// pointers and occupancy
	rob_tag_t              head;
	rob_tag_t              tail;
	logic [CNT_BITS-1:0]   count;

	// per entry state
	logic [DEPTH-1:0]      done;
	data_t                 result [DEPTH];
	reg_idx_t              dest   [DEPTH];
	retire_status_t        status [DEPTH];

	logic do_alloc;
	logic do_retire;

	////////////////////////////////////////////////////////////
	// handshakes
	////////////////////////////////////////////////////////////

	// room for one more
	assign alloc_ready = count != CNT_BITS'(DEPTH);
	assign alloc_tag   = tail;
	assign do_alloc    = alloc_valid && alloc_ready;

	// head presented without a register stage
	assign out_valid  = (count != '0) && done[head];
	assign out_result = result[head];
	assign out_dest   = dest[head];
	assign out_status = status[head];
	assign do_retire  = out_valid && out_ready;

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			done   <= '0;
			halted <= 1'b0;
		end else begin
			if (do_alloc) begin
				tail       <= tail + 1'b1;
				// illegal and halt arrive already complete
				done[tail] <= alloc_done;
			end
			// completion from any lane, entry was reserved at dispatch
			for (int l = 0; l < `LANES; l++) begin
				if (wb_valid[l]) begin
					done[wb_tag[l]] <= 1'b1;
				end
			end
			if (do_retire) begin
				head <= head + 1'b1;
				if (out_status == HALTED) begin
					halted <= 1'b1;
				end
			end
			// occupancy
			case ({do_alloc, do_retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// entry payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_alloc) begin
			// zero stays for entries that never see a lane
			result[tail] <= '0;
			dest[tail]   <= alloc_dest;
			status[tail] <= alloc_status;
		end
		// tail is always a free slot, so no clash with a writeback
		for (int l = 0; l < `LANES; l++) begin
			if (wb_valid[l]) begin
				result[wb_tag[l]] <= wb_result[l];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/uarch_pkg.sv ====
// uarch package
// microarchitectural types internal to the core

`default_nettype none

`include "core_defines.svh"

package uarch_pkg;

	// reorder buffer slot, wraps naturally since depth is 2^n
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_tag_t;

	// lane number, kept one bit wide for a single lane build
	typedef logic [((`LANES > 1) ? $clog2(`LANES) : 1)-1:0] lane_idx_t;

endpackage

`default_nettype wire
